// ==== common/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

	typedef logic [31:0] instrWord;
	typedef logic [4:0] regIdx;
	typedef logic [2:0] funct3T;
	typedef logic [6:0] funct7T;

	// Major opcodes, bits [6:0]
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OPIMM  = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcodeE;

	// Branch conditions as coded in funct3
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} funct3Br;

	// ALU funct3 codes shared by OP and OP-IMM
	localparam funct3T F3_ADD  = 3'b000;
	localparam funct3T F3_SLL  = 3'b001;
	localparam funct3T F3_SLT  = 3'b010;
	localparam funct3T F3_SLTU = 3'b011;
	localparam funct3T F3_XOR  = 3'b100;
	localparam funct3T F3_SR   = 3'b101;
	localparam funct3T F3_OR   = 3'b110;
	localparam funct3T F3_AND  = 3'b111;

	localparam instrWord INSTR_EBREAK = 32'h0010_0073;

endpackage

`default_nettype wire

// ==== common/coreCfgPkg.sv ====
`default_nettype none

package coreCfgPkg;

	typedef logic [31:0] xWord;
	typedef logic [3:0] byteEn;

	localparam byteEn BE_WORD = 4'b1111;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASSB
	} aluOpE;

	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pcSelE;

	// IMMPC is the pc-relative immediate, for AUIPC
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK, WB_IMMPC} wbSelE;

	typedef struct packed {
		logic regWrite;
		logic memWrite;
		logic aluSrcImm; // b operand from imm
		logic aluSrcPc;  // a operand from pc
		aluOpE aluOp;
		pcSelE pcSel;
		wbSelE wbSel;
		rvIsaPkg::funct3Br brCond;
		logic isHalt;
	} ctrlBus;

endpackage

`default_nettype wire

// ==== core/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit import rvIsaPkg::*; import coreCfgPkg::*; (
	input xWord a,
	input xWord b,
	input aluOpE op,
	input funct3Br brCond,
	output xWord y,
	output logic brTaken
);

	logic [4:0] shamt;
	logic eq;
	logic lt;
	logic ltu;

	assign shamt = b[4:0];
	assign eq = (a == b);
	assign lt = ($signed(a) < $signed(b));
	assign ltu = (a < b);

	always_comb begin
		case (op)
			ALU_ADD:   y = a + b;
			ALU_SUB:   y = a - b;
			ALU_SLL:   y = a << shamt;
			ALU_SLT:   y = {31'b0, lt};
			ALU_SLTU:  y = {31'b0, ltu};
			ALU_XOR:   y = a ^ b;
			ALU_SRL:   y = a >> shamt;
			ALU_SRA:   y = $signed(a) >>> shamt;
			ALU_OR:    y = a | b;
			ALU_AND:   y = a & b;
			ALU_PASSB: y = b;
			default:   y = '0;
		endcase
	end

	always_comb begin
		case (brCond)
			BR_EQ:   brTaken = eq;
			BR_NE:   brTaken = !eq;
			BR_LT:   brTaken = lt;
			BR_GE:   brTaken = !lt;
			BR_LTU:  brTaken = ltu;
			BR_GEU:  brTaken = !ltu;
			default: brTaken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== core/ctrlDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrlDecoder import rvIsaPkg::*; import coreCfgPkg::*; (
	input instrWord instr,
	output ctrlBus ctrl,
	output xWord imm
);

	funct3T f3;
	funct7T f7;
	xWord immI;
	xWord immS;
	xWord immB;
	xWord immU;
	xWord immJ;

	assign f3 = instr[14:12];
	assign f7 = instr[31:25];

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// alt selects SUB or SRA
	function automatic aluOpE aluFromF3(input funct3T fn, input logic alt);
		aluOpE op;
		case (fn)
			F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
			F3_SLL:  op = ALU_SLL;
			F3_SLT:  op = ALU_SLT;
			F3_SLTU: op = ALU_SLTU;
			F3_XOR:  op = ALU_XOR;
			F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
			F3_OR:   op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	always_comb begin
		ctrl = '0;
		ctrl.pcSel = PC_SEQ;
		imm = immI;
		case (opcodeE'(instr[6:0]))
			OPC_LUI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = ALU_PASSB;
				imm = immU;
			end
			OPC_AUIPC: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = WB_IMMPC;
				imm = immU;
			end
			OPC_JAL: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcPc = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.pcSel = PC_JAL;
				ctrl.wbSel = WB_LINK;
				imm = immJ;
			end
			OPC_JALR: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.pcSel = PC_JALR;
				ctrl.wbSel = WB_LINK;
			end
			OPC_BRANCH: begin
				ctrl.pcSel = PC_BRANCH;
				ctrl.brCond = funct3Br'(f3);
				imm = immB;
			end
			OPC_LOAD: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.wbSel = WB_MEM; // LW only
			end
			OPC_STORE: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				imm = immS;
			end
			OPC_OPIMM: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = aluFromF3(f3, (f3 == F3_SR) && f7[5]);
			end
			OPC_OP: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = aluFromF3(f3, f7[5]);
			end
			OPC_SYSTEM: ctrl.isHalt = (instr == INSTR_EBREAK); // ECALL falls through
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== core/riscvCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvCore import rvIsaPkg::*; import coreCfgPkg::*; (
	input logic CLK,
	input logic RSTn,

	output xWord iAddr,
	input instrWord iData,

	output regIdx ra1,
	output regIdx ra2,
	output regIdx wa,
	input xWord rd1,
	input xWord rd2,
	output xWord wd,
	output logic we,

	output xWord dAddr,
	output xWord dWdata,
	output byteEn dBe,
	output logic dWe,
	input xWord dRdata,

	output logic halt,
	output xWord numInst
);

	xWord pc;
	xWord pcPlus4;
	xWord pcImm;
	xWord nextPc;
	xWord imm;
	xWord aluA;
	xWord aluB;
	xWord aluY;
	ctrlBus ctrl;
	logic brTaken;
	logic halted;
	logic live;

	ctrlDecoder dec0 (
		.instr(iData),
		.ctrl(ctrl),
		.imm(imm)
	);

	assign aluA = ctrl.aluSrcPc ? pc : rd1;
	assign aluB = ctrl.aluSrcImm ? imm : rd2;

	aluUnit alu0 (
		.a(aluA),
		.b(aluB),
		.op(ctrl.aluOp),
		.brCond(ctrl.brCond),
		.y(aluY),
		.brTaken(brTaken)
	);

	assign iAddr = pc;
	assign ra1 = iData[19:15];
	assign ra2 = iData[24:20];
	assign wa = iData[11:7];

	assign pcPlus4 = pc + 32'd4;
	assign pcImm = pc + imm; // branch target, AUIPC result

	// Nothing commits in reset or after EBREAK
	assign live = !halted && !RSTn;
	assign we = ctrl.regWrite && live;
	assign dWe = ctrl.memWrite && live;
	assign dBe = ctrl.memWrite ? BE_WORD : '0;
	assign dAddr = aluY;
	assign dWdata = rd2;

	always_comb begin
		case (ctrl.pcSel)
			PC_BRANCH: nextPc = brTaken ? pcImm : pcPlus4;
			PC_JAL:    nextPc = aluY;
			PC_JALR:   nextPc = {aluY[31:1], 1'b0};
			default:   nextPc = pcPlus4;
		endcase
	end

	always_comb begin
		case (ctrl.wbSel)
			WB_MEM:   wd = dRdata;
			WB_LINK:  wd = pcPlus4;
			WB_IMMPC: wd = pcImm;
			default:  wd = aluY;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= '0;
			numInst <= '0;
			halted <= 1'b0;
		end else if (!halted) begin
			pc <= nextPc;
			numInst <= numInst + 32'd1;
			if (ctrl.isHalt)
				halted <= 1'b1; // EBREAK still counts
		end
	end

	assign halt = halted;

	pcAligned: assert property (@(posedge CLK) disable iff (RSTn) pc[1:0] == 2'b00)
		else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile import rvIsaPkg::*; import coreCfgPkg::*; (
	input logic CLK,
	input logic RSTn,
	input regIdx ra1,
	input regIdx ra2,
	input regIdx wa,
	input xWord wd,
	input logic we,
	output xWord rd1,
	output xWord rd2
);

	xWord regs [32];

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// x0 hardwired
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// ==== design/instRom.sv ====
`timescale 1ns/1ps
`default_nettype none

module instRom import rvIsaPkg::*; import coreCfgPkg::*; #(
	parameter int IMEM_AW = 10
) (
	input xWord addr, // byte address
	output instrWord data
);

	instrWord mem [2**IMEM_AW];

	initial begin
		for (int i = 0; i < 2**IMEM_AW; i++)
			mem[i] = '0; // unused words decode as no-ops
		$readmemh("program.hex", mem);
	end

	assign data = mem[addr[IMEM_AW+1:2]];

endmodule

`default_nettype wire

// ==== design/dataRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataRam import coreCfgPkg::*; #(
	parameter int DMEM_AW = 10
) (
	input logic CLK,
	input xWord addr, // byte address
	input xWord wdata,
	input byteEn be,
	input logic we,
	output xWord rdata
);

	xWord mem [2**DMEM_AW];
	logic [DMEM_AW-1:0] wordIdx;

	assign wordIdx = addr[DMEM_AW+1:2];

	always_ff @(posedge CLK) begin
		if (we) begin
			for (int lane = 0; lane < 4; lane++)
				if (be[lane])
					mem[wordIdx][8*lane +: 8] <= wdata[8*lane +: 8];
		end
	end

	assign rdata = mem[wordIdx];

	// Core must never issue a store with no lanes
	noEmptyWrite: assert property (@(posedge CLK) we |-> be != '0)
		else $error("data write with empty byte mask at %h", addr);

endmodule

`default_nettype wire

// ==== design/riscvSys.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvSys import rvIsaPkg::*; import coreCfgPkg::*; #(
	parameter int IMEM_AW = 10,
	parameter int DMEM_AW = 10
) (
	input logic CLK,
	input logic RSTn,
	output logic halt,
	output xWord numInst,
	output xWord outputPort,
	output logic outputValid
);

	xWord iAddr;
	instrWord iData;
	regIdx ra1;
	regIdx ra2;
	regIdx wa;
	xWord rd1;
	xWord rd2;
	xWord wd;
	logic we;
	xWord dAddr;
	xWord dWdata;
	xWord dRdata;
	byteEn dBe;
	logic dWe;

	riscvCore core0 (
		.CLK(CLK), .RSTn(RSTn),
		.iAddr(iAddr), .iData(iData),
		.ra1(ra1), .ra2(ra2), .wa(wa), .rd1(rd1), .rd2(rd2), .wd(wd), .we(we),
		.dAddr(dAddr), .dWdata(dWdata), .dBe(dBe), .dWe(dWe), .dRdata(dRdata),
		.halt(halt), .numInst(numInst)
	);

	regFile rf0 (
		.CLK(CLK), .RSTn(RSTn),
		.ra1(ra1), .ra2(ra2), .wa(wa), .wd(wd), .we(we),
		.rd1(rd1), .rd2(rd2)
	);

	instRom #(.IMEM_AW(IMEM_AW)) rom0 (.addr(iAddr), .data(iData));

	dataRam #(.DMEM_AW(DMEM_AW)) ram0 (
		.CLK(CLK), .addr(dAddr), .wdata(dWdata), .be(dBe), .we(dWe), .rdata(dRdata)
	);

	// Test port mirrors the register write
	assign outputPort = wd;
	assign outputValid = we;

endmodule

`default_nettype wire

// ==== sim/tbRiscvSys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbRiscvSys import coreCfgPkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DLY = 5;
	localparam int RESET_CYCLES = 16;
	localparam int PROG_INSTR = 22; // words in program.hex
	localparam int PATH_INSTR = 20; // retired on the taken path, EBREAK included
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + PROG_INSTR + 40;
	localparam int HALT_HOLD = 10;
	localparam int NUM_WR = 16;
	localparam int NUM_TESTS = 5;

	// Register write data in program order
	localparam xWord EXP_WR [NUM_WR] = '{
		32'h0000_0005, // addi x1
		32'hFFFF_FFFD, // addi x2, -3
		32'h0000_0008, // sub
		32'hFFFF_FFF8, // xor
		32'h0000_0001, // slt
		32'h0000_0000, // sltu
		32'hFFFF_FFFC, // sra
		32'h0000_0500, // sll
		32'h1234_5000, // lui
		32'h0000_1024, // auipc at 0x24
		32'h1234_5000, // lw of the stored word
		32'h1234_5005, // or
		32'h0000_0055, // addi after not-taken bne
		32'h0000_0048, // jal link
		32'h0000_0054, // jalr link
		32'h0000_0066  // jalr target
	};

	logic CLK;
	logic RSTn;
	logic halt;
	xWord numInst;
	xWord outputPort;
	logic outputValid;

	int wrIdx;
	logic [3:0] wrSlot;
	int errCount = 0;
	int errMark = 0;
	int failedTests = 0;
	int cycleCnt = 0;

	riscvSys #(.IMEM_AW(10), .DMEM_AW(10)) dut0 (
		.CLK(CLK),
		.RSTn(RSTn),
		.halt(halt),
		.numInst(numInst),
		.outputPort(outputPort),
		.outputValid(outputValid)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	task automatic logMismatch(input string msg);
		$display("error %0t: %s", $time, msg);
		errCount++;
	endtask

	task automatic logFailure(input string msg);
		$display("%s", msg);
		errCount++;
	endtask

	task automatic endTest(input string name);
		if (errCount == errMark) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d failed checks", name, errCount - errMark);
			failedTests++;
		end
		errMark = errCount;
	endtask

	task automatic waitWrites(input int bound);
		wait (wrIdx >= bound || halt);
		#DRIVE_DLY;
	endtask

	always @(posedge CLK) begin
		if (RSTn)
			wrIdx <= 0;
		else if (outputValid)
			wrIdx <= wrIdx + 1;
	end

	assign wrSlot = wrIdx[3:0];

	resetQuiet: assert property (@(posedge CLK) RSTn |-> !outputValid)
		else logFailure("register write enable was high during reset");

	resetClears: assert property (@(posedge CLK) RSTn |=> (numInst == '0 && !halt))
		else logMismatch($sformatf("after a reset edge numInst is %0d, halt is %b",
			$sampled(numInst), $sampled(halt)));

	wrValue: assert property (@(posedge CLK) disable iff (RSTn)
		(outputValid && wrIdx < NUM_WR) |-> outputPort == EXP_WR[wrSlot])
		else logMismatch($sformatf("write %0d is %h, expected %h", $sampled(wrIdx),
			$sampled(outputPort), EXP_WR[$sampled(wrSlot)]));

	wrCount: assert property (@(posedge CLK) disable iff (RSTn)
		outputValid |-> wrIdx < NUM_WR)
		else logFailure("the core made more register writes than the program has");

	// Values only the jumped-over ADDIs produce
	skippedNever: assert property (@(posedge CLK) disable iff (RSTn)
		outputValid |-> (outputPort != 32'h7FF && outputPort != 32'h3AB))
		else logFailure("an instruction that should have been skipped wrote back");

	haltCount: assert property (@(posedge CLK) disable iff (RSTn)
		$rose(halt) |-> numInst == xWord'(PATH_INSTR))
		else logMismatch($sformatf("numInst at halt is %0d, expected %0d",
			$sampled(numInst), PATH_INSTR));

	haltQuiet: assert property (@(posedge CLK) disable iff (RSTn) halt |-> !outputValid)
		else logFailure("a register write happened after halt");

	haltFrozen: assert property (@(posedge CLK) disable iff (RSTn) halt |=> $stable(numInst))
		else logMismatch($sformatf("numInst moved to %0d while halted", $sampled(numInst)));

	initial begin
		RSTn = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK);
		#DRIVE_DLY;
		RSTn = 1'b0;
		@(posedge CLK);
		#DRIVE_DLY;
		endTest("reset");
		waitWrites(10);
		endTest("ALU and immediates");
		waitWrites(12);
		endTest("memory");
		waitWrites(NUM_WR);
		endTest("branches and jumps");
		wait (halt);
		repeat (HALT_HOLD) @(posedge CLK);
		#DRIVE_DLY;
		allWrites: assert (wrIdx == NUM_WR)
			else logFailure($sformatf("only %0d of %0d register writes were seen",
				wrIdx, NUM_WR));
		endTest("halt");
		$display("%0d tests, %0d failed, %0d failed checks", NUM_TESTS, failedTests, errCount);
		if (errCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// Run ends here only if EBREAK never retires
	always @(posedge CLK) begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt == TIMEOUT_CYCLES) begin
			$display("Timeout: halt never came within %0d cycles", TIMEOUT_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== sim/program.hex ====
// One RV32I instruction word per line, from byte address 0 upward
// Column 1 is the word, the comment gives its address and assembly
00500093 // 00 addi x1, x0, 5
FFD00113 // 04 addi x2, x0, -3
402081B3 // 08 sub x3, x1, x2
0020C233 // 0C xor x4, x1, x2
001122B3 // 10 slt x5, x2, x1
00113333 // 14 sltu x6, x2, x1
405253B3 // 18 sra x7, x4, x5
00309433 // 1C sll x8, x1, x3
123454B7 // 20 lui x9, 0x12345
00001517 // 24 auipc x10, 0x1
00902823 // 28 sw x9, 16(x0)
01002583 // 2C lw x11, 16(x0)
0015E633 // 30 or x12, x11, x1
00108463 // 34 beq x1, x1, +8
7FF00693 // 38 addi x13, x0, 0x7FF
00109463 // 3C bne x1, x1, +8
05500693 // 40 addi x13, x0, 0x55
00C0076F // 44 jal x14, +12
06600793 // 48 addi x15, x0, 0x66
00100073 // 4C ebreak
00070867 // 50 jalr x16, 0(x14)
3AB00893 // 54 addi x17, x0, 0x3AB

// ==== tb.f ====
common/rvIsaPkg.sv
common/coreCfgPkg.sv
core/aluUnit.sv
core/ctrlDecoder.sv
core/riscvCore.sv
design/regFile.sv
design/instRom.sv
design/dataRam.sv
design/riscvSys.sv
sim/tbRiscvSys.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -euo pipefail

cd "$(dirname "$0")"
ROOT="$(pwd)"

verilator --binary --timing --assert --top-module tbRiscvSys -Mdir obj_dir -f tb.f

# The ROM loads program.hex from the working directory
(cd sim && "$ROOT/obj_dir/VtbRiscvSys") | tee sim.log

if grep -q "Done: errors found" sim.log; then
	exit 1
fi
